// File: logic/cpl_buffer_writer.sv
//##########################################################################
// Completion payload writes into the packet buffer
//##########################################################################
`default_nettype none

module cpl_buffer_writer (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            i_first_stb,
  input  wire logic                            i_beat_stb,
  input  wire logic [tlp_pkg::DW_W-1:0]        i_data,
  input  wire logic [tlp_pkg::LADDR_W-1:0]     i_lower_addr,
  input  wire logic [ctrl_pkg::BUF_OFS_W-1:0]  i_buf_offset,
  output logic                                 o_buf_we,
  output logic      [ctrl_pkg::BUF_ADDR_W-1:0] o_buf_addr,
  output logic      [tlp_pkg::DW_W-1:0]        o_buf_data
);

  logic [ctrl_pkg::BUF_OFS_W-1:0] w_base;

  // Start of the completion in the buffer
  assign w_base = i_buf_offset -
                  {{(ctrl_pkg::BUF_OFS_W-tlp_pkg::LADDR_W){1'b0}}, i_lower_addr};

  always_ff @(posedge clk) begin
    if (rst) begin
      o_buf_we   <= 1'b0;
      o_buf_addr <= '0;
    end else begin
      o_buf_we <= i_beat_stb;
      if (i_first_stb) begin
        o_buf_addr <= w_base[ctrl_pkg::BUF_ADDR_W-1:0];
      end else if (i_beat_stb) begin
        o_buf_addr <= o_buf_addr + {{(ctrl_pkg::BUF_ADDR_W-1){1'b0}}, 1'b1};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_beat_stb) begin
      o_buf_data <= i_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/ctrl_pkg.sv
//##########################################################################
// Control window register map and command offsets
//##########################################################################
`default_nettype none

package ctrl_pkg;

  localparam int BUF_ADDR_W = 11;
  localparam int BUF_OFS_W  = 13;

  // Register offsets in dwords from the window base
  localparam logic [31:0] REG_BUFFER_READY = 32'd0;
  localparam logic [31:0] REG_WRITE_A      = 32'd1;
  localparam logic [31:0] REG_WRITE_B      = 32'd2;
  localparam logic [31:0] REG_READ_A       = 32'd3;
  localparam logic [31:0] REG_READ_B       = 32'd4;
  localparam logic [31:0] REG_BUFFER_SIZE  = 32'd5;

  // First command offset
  localparam logic [31:0] CMD_OFFSET = 32'd16;

  typedef enum logic [31:0] {
    CMD_RESET          = 32'd16,
    CMD_PER_WRITE      = 32'd17,
    CMD_PER_WRITE_FIFO = 32'd18,
    CMD_PER_READ       = 32'd19,
    CMD_PER_READ_FIFO  = 32'd20,
    CMD_MEM_WRITE      = 32'd21,
    CMD_MEM_READ       = 32'd22,
    CMD_DMA_WRITE      = 32'd23,
    CMD_DMA_READ       = 32'd24,
    CMD_PING           = 32'd25
  } cmd_t;

endpackage

`default_nettype wire

// File: logic/ingress_ctrl.sv
//##########################################################################
// Ingress packet FSM with stream ready, payload count and end-of-packet
// status strobes
//##########################################################################
`default_nettype none

module ingress_ctrl (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       i_valid,
  input  wire logic                       i_last,
  input  wire tlp_pkg::tlp_kind_t         i_kind,
  input  wire logic [tlp_pkg::LEN_W-1:0]  i_length,
  input  wire logic [tlp_pkg::TAG_W-1:0]  i_tag,
  input  wire logic [tlp_pkg::STS_W-1:0]  i_sts,
  output logic                            o_ready,
  output logic                            o_hdr_we,
  output logic      [1:0]                 o_hdr_idx,
  output logic                            o_mwr_stb,
  output logic                            o_cpl_first_stb,
  output logic                            o_cpl_beat_stb,
  output logic                            o_cplt_pkt_stb,
  output logic      [tlp_pkg::LEN_W-1:0]  o_cplt_pkt_cnt,
  output logic      [tlp_pkg::TAG_W-1:0]  o_cplt_pkt_tag,
  output logic      [tlp_pkg::STS_W-1:0]  o_cplt_sts,
  output logic                            o_unknown_tlp_stb,
  output logic                            o_unexpected_end_stb
);

  typedef enum logic [2:0] {
    HEADER,
    MWR_DATA,
    CPL_DATA,
    FLUSH,
    DONE
  } state_t;

  state_t                    r_state;
  logic [1:0]                r_hdr_cnt;
  logic [tlp_pkg::LEN_W-1:0] r_cnt;
  logic [tlp_pkg::LEN_W-1:0] w_cnt_next;
  logic                      r_unknown;
  logic                      r_cpl_full;
  logic                      w_xfer;
  logic                      w_hdr_end;
  logic                      w_unknown;
  logic                      w_cpl_report;

  assign o_ready    = (r_state != DONE);
  assign w_xfer     = i_valid && o_ready;
  assign w_hdr_end  = (r_hdr_cnt == 2'(tlp_pkg::HDR_DWORDS - 1));
  assign w_unknown  = (i_kind == tlp_pkg::TLP_UNKNOWN);
  assign w_cnt_next = r_cnt + {{(tlp_pkg::LEN_W-1){1'b0}}, 1'b1};

  assign o_hdr_we        = w_xfer && (r_state == HEADER);
  assign o_hdr_idx       = r_hdr_cnt;
  assign o_mwr_stb       = w_xfer && (r_state == MWR_DATA);
  assign o_cpl_beat_stb  = w_xfer && (r_state == CPL_DATA);
  assign o_cpl_first_stb = o_cpl_beat_stb && (r_cnt == '0);

  // Full completion ends either in the data state or after extra beats
  assign w_cpl_report = w_xfer && i_last &&
                        (((r_state == CPL_DATA) && (w_cnt_next == i_length)) ||
                         ((r_state == FLUSH) && r_cpl_full));

  always_ff @(posedge clk) begin
    if (rst) begin
      r_state              <= DONE;
      r_hdr_cnt            <= '0;
      r_cnt                <= '0;
      r_unknown            <= 1'b0;
      r_cpl_full           <= 1'b0;
      o_cplt_pkt_stb       <= 1'b0;
      o_cplt_pkt_cnt       <= '0;
      o_cplt_pkt_tag       <= '0;
      o_cplt_sts           <= '0;
      o_unknown_tlp_stb    <= 1'b0;
      o_unexpected_end_stb <= 1'b0;
    end else begin
      o_unknown_tlp_stb    <= 1'b0;
      o_unexpected_end_stb <= 1'b0;
      o_cplt_pkt_stb       <= w_cpl_report;
      if (w_cpl_report) begin
        o_cplt_pkt_cnt <= i_length;
        o_cplt_pkt_tag <= i_tag;
      end

      case (r_state)
        HEADER: begin
          if (w_xfer) begin
            r_hdr_cnt <= r_hdr_cnt + 2'd1;
            if (i_last && !w_hdr_end) begin
              // Packet ended inside the header
              r_hdr_cnt            <= '0;
              o_unexpected_end_stb <= 1'b1;
              r_state              <= DONE;
            end else if (w_hdr_end) begin
              r_hdr_cnt  <= '0;
              r_cnt      <= '0;
              r_unknown  <= w_unknown;
              r_cpl_full <= 1'b0;
              if ((i_kind == tlp_pkg::TLP_CPL || i_kind == tlp_pkg::TLP_CPLD) &&
                  (i_sts != '0)) begin
                o_cplt_sts <= i_sts;
              end
              if (i_last) begin
                o_unknown_tlp_stb    <= w_unknown;
                o_unexpected_end_stb <= (i_kind == tlp_pkg::TLP_MWR) ||
                                        (i_kind == tlp_pkg::TLP_CPLD);
                r_state              <= DONE;
              end else begin
                case (i_kind)
                  tlp_pkg::TLP_MWR:  r_state <= MWR_DATA;
                  tlp_pkg::TLP_CPLD: r_state <= CPL_DATA;
                  default:           r_state <= FLUSH;
                endcase
              end
            end
          end
        end
        MWR_DATA: begin
          // Only the first payload dword is decoded
          if (w_xfer) begin
            r_state <= i_last ? DONE : FLUSH;
          end
        end
        CPL_DATA: begin
          if (w_xfer) begin
            r_cnt <= w_cnt_next;
            if (i_last) begin
              o_unexpected_end_stb <= (w_cnt_next != i_length);
              r_state              <= DONE;
            end else if (w_cnt_next == i_length) begin
              r_cpl_full <= 1'b1;
              r_state    <= FLUSH;
            end
          end
        end
        FLUSH: begin
          if (w_xfer && i_last) begin
            o_unknown_tlp_stb <= r_unknown;
            r_state           <= DONE;
          end
        end
        default: begin
          r_state <= HEADER;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/pcie_ingress.sv
//##########################################################################
// PCIe TLP ingress parser top
//##########################################################################
`default_nettype none

module pcie_ingress (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            i_valid,
  input  wire logic [tlp_pkg::DW_W-1:0]        i_data,
  input  wire logic                            i_last,
  input  wire logic [tlp_pkg::DW_W-1:0]        i_ctrl_base,
  input  wire logic [ctrl_pkg::BUF_OFS_W-1:0]  i_buf_offset,
  output logic                                 o_ready,
  output logic      [tlp_pkg::DW_W-1:0]        o_write_a_addr,
  output logic      [tlp_pkg::DW_W-1:0]        o_write_b_addr,
  output logic      [tlp_pkg::DW_W-1:0]        o_read_a_addr,
  output logic      [tlp_pkg::DW_W-1:0]        o_read_b_addr,
  output logic      [tlp_pkg::DW_W-1:0]        o_buffer_size,
  output logic      [tlp_pkg::DW_W-1:0]        o_ping_value,
  output logic      [tlp_pkg::DW_W-1:0]        o_cmd_data_count,
  output logic                                 o_update_buf_stb,
  output logic      [1:0]                      o_update_buf,
  output logic                                 o_reg_write_stb,
  output logic                                 o_cmd_rst_stb,
  output logic                                 o_cmd_wr_stb,
  output logic                                 o_cmd_rd_stb,
  output logic                                 o_cmd_ping_stb,
  output logic                                 o_cmd_unknown_stb,
  output logic                                 o_cmd_flg_fifo_stb,
  output logic                                 o_cmd_flg_sel_per_stb,
  output logic                                 o_cmd_flg_sel_mem_stb,
  output logic                                 o_cmd_flg_sel_dma_stb,
  output logic                                 o_buf_we,
  output logic      [ctrl_pkg::BUF_ADDR_W-1:0] o_buf_addr,
  output logic      [tlp_pkg::DW_W-1:0]        o_buf_data,
  output logic                                 o_cplt_pkt_stb,
  output logic      [tlp_pkg::LEN_W-1:0]       o_cplt_pkt_cnt,
  output logic      [tlp_pkg::TAG_W-1:0]       o_cplt_pkt_tag,
  output logic      [tlp_pkg::STS_W-1:0]       o_cplt_sts,
  output logic                                 o_unknown_tlp_stb,
  output logic                                 o_unexpected_end_stb
);

  tlp_pkg::tlp_kind_t          w_kind;
  logic [tlp_pkg::LEN_W-1:0]   w_length;
  logic [tlp_pkg::DW_W-1:0]    w_addr;
  logic [tlp_pkg::TAG_W-1:0]   w_tag;
  logic [tlp_pkg::LADDR_W-1:0] w_lower_addr;
  logic [tlp_pkg::STS_W-1:0]   w_sts;
  logic                        w_hdr_we;
  logic [1:0]                  w_hdr_idx;
  logic                        w_mwr_stb;
  logic                        w_cpl_first_stb;
  logic                        w_cpl_beat_stb;

  // Same-named ports connect straight to the top ports
  ingress_ctrl u_ingress_ctrl (
    .*,
    .i_kind          (w_kind),
    .i_length        (w_length),
    .i_tag           (w_tag),
    .i_sts           (w_sts),
    .o_hdr_we        (w_hdr_we),
    .o_hdr_idx       (w_hdr_idx),
    .o_mwr_stb       (w_mwr_stb),
    .o_cpl_first_stb (w_cpl_first_stb),
    .o_cpl_beat_stb  (w_cpl_beat_stb)
  );

  tlp_hdr_capture u_tlp_hdr_capture (
    .*,
    .i_hdr_we     (w_hdr_we),
    .i_hdr_idx    (w_hdr_idx),
    .o_kind       (w_kind),
    .o_length     (w_length),
    .o_addr       (w_addr),
    .o_tag        (w_tag),
    .o_lower_addr (w_lower_addr),
    .o_sts        (w_sts)
  );

  reg_write_decoder u_reg_write_decoder (
    .*,
    .i_mwr_stb (w_mwr_stb),
    .i_addr    (w_addr)
  );

  cpl_buffer_writer u_cpl_buffer_writer (
    .*,
    .i_first_stb  (w_cpl_first_stb),
    .i_beat_stb   (w_cpl_beat_stb),
    .i_lower_addr (w_lower_addr)
  );

endmodule

`default_nettype wire

// File: logic/reg_write_decoder.sv
//##########################################################################
// Control window write decode into registers and command strobes
//##########################################################################
`default_nettype none

module reg_write_decoder (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      i_mwr_stb,
  input  wire logic [tlp_pkg::DW_W-1:0]  i_addr,
  input  wire logic [tlp_pkg::DW_W-1:0]  i_ctrl_base,
  input  wire logic [tlp_pkg::DW_W-1:0]  i_data,
  output logic      [tlp_pkg::DW_W-1:0]  o_write_a_addr,
  output logic      [tlp_pkg::DW_W-1:0]  o_write_b_addr,
  output logic      [tlp_pkg::DW_W-1:0]  o_read_a_addr,
  output logic      [tlp_pkg::DW_W-1:0]  o_read_b_addr,
  output logic      [tlp_pkg::DW_W-1:0]  o_buffer_size,
  output logic      [tlp_pkg::DW_W-1:0]  o_ping_value,
  output logic      [tlp_pkg::DW_W-1:0]  o_cmd_data_count,
  output logic                           o_update_buf_stb,
  output logic      [1:0]                o_update_buf,
  output logic                           o_reg_write_stb,
  output logic                           o_cmd_rst_stb,
  output logic                           o_cmd_wr_stb,
  output logic                           o_cmd_rd_stb,
  output logic                           o_cmd_ping_stb,
  output logic                           o_cmd_unknown_stb,
  output logic                           o_cmd_flg_fifo_stb,
  output logic                           o_cmd_flg_sel_per_stb,
  output logic                           o_cmd_flg_sel_mem_stb,
  output logic                           o_cmd_flg_sel_dma_stb
);

  logic [tlp_pkg::DW_W-1:0] w_ofs;

  // Dword offset into the control window
  assign w_ofs = (i_addr - i_ctrl_base) >> 2;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_write_a_addr   <= '0;
      o_write_b_addr   <= '0;
      o_read_a_addr    <= '0;
      o_read_b_addr    <= '0;
      o_buffer_size    <= '0;
      o_ping_value     <= '0;
      o_cmd_data_count <= '0;
      o_update_buf     <= '0;
    end else if (i_mwr_stb) begin
      if (w_ofs < ctrl_pkg::CMD_OFFSET) begin
        case (w_ofs)
          ctrl_pkg::REG_BUFFER_READY: o_update_buf   <= i_data[1:0];
          ctrl_pkg::REG_WRITE_A:      o_write_a_addr <= i_data;
          ctrl_pkg::REG_WRITE_B:      o_write_b_addr <= i_data;
          ctrl_pkg::REG_READ_A:       o_read_a_addr  <= i_data;
          ctrl_pkg::REG_READ_B:       o_read_b_addr  <= i_data;
          ctrl_pkg::REG_BUFFER_SIZE:  o_buffer_size  <= i_data;
          default: ;
        endcase
      end else begin
        o_cmd_data_count <= i_data;
        if (w_ofs == ctrl_pkg::CMD_PING) begin
          o_ping_value <= i_data;
        end
      end
    end
  end

  // Single cycle strobes
  always_ff @(posedge clk) begin
    o_reg_write_stb       <= 1'b0;
    o_update_buf_stb      <= 1'b0;
    o_cmd_rst_stb         <= 1'b0;
    o_cmd_wr_stb          <= 1'b0;
    o_cmd_rd_stb          <= 1'b0;
    o_cmd_ping_stb        <= 1'b0;
    o_cmd_unknown_stb     <= 1'b0;
    o_cmd_flg_fifo_stb    <= 1'b0;
    o_cmd_flg_sel_per_stb <= 1'b0;
    o_cmd_flg_sel_mem_stb <= 1'b0;
    o_cmd_flg_sel_dma_stb <= 1'b0;
    if (!rst && i_mwr_stb) begin
      if (w_ofs < ctrl_pkg::CMD_OFFSET) begin
        o_reg_write_stb  <= 1'b1;
        o_update_buf_stb <= (w_ofs == ctrl_pkg::REG_BUFFER_READY);
      end else begin
        case (w_ofs)
          ctrl_pkg::CMD_RESET: o_cmd_rst_stb <= 1'b1;
          ctrl_pkg::CMD_PER_WRITE, ctrl_pkg::CMD_PER_WRITE_FIFO: begin
            o_cmd_flg_sel_per_stb <= 1'b1;
            o_cmd_wr_stb          <= 1'b1;
            o_cmd_flg_fifo_stb    <= (w_ofs == ctrl_pkg::CMD_PER_WRITE_FIFO);
          end
          ctrl_pkg::CMD_PER_READ, ctrl_pkg::CMD_PER_READ_FIFO: begin
            o_cmd_flg_sel_per_stb <= 1'b1;
            o_cmd_rd_stb          <= 1'b1;
            o_cmd_flg_fifo_stb    <= (w_ofs == ctrl_pkg::CMD_PER_READ_FIFO);
          end
          ctrl_pkg::CMD_MEM_WRITE, ctrl_pkg::CMD_MEM_READ: begin
            o_cmd_flg_sel_mem_stb <= 1'b1;
            o_cmd_wr_stb          <= (w_ofs == ctrl_pkg::CMD_MEM_WRITE);
            o_cmd_rd_stb          <= (w_ofs == ctrl_pkg::CMD_MEM_READ);
          end
          ctrl_pkg::CMD_DMA_WRITE, ctrl_pkg::CMD_DMA_READ: begin
            o_cmd_flg_sel_dma_stb <= 1'b1;
            o_cmd_wr_stb          <= (w_ofs == ctrl_pkg::CMD_DMA_WRITE);
            o_cmd_rd_stb          <= (w_ofs == ctrl_pkg::CMD_DMA_READ);
          end
          ctrl_pkg::CMD_PING: o_cmd_ping_stb    <= 1'b1;
          default:            o_cmd_unknown_stb <= 1'b1;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/tlp_hdr_capture.sv
//##########################################################################
// Header dword store with field decode for 3DW TLPs
//##########################################################################
`default_nettype none

module tlp_hdr_capture (
  input  wire logic                        clk,
  input  wire logic                        i_hdr_we,
  input  wire logic [1:0]                  i_hdr_idx,
  input  wire logic [tlp_pkg::DW_W-1:0]    i_data,
  output tlp_pkg::tlp_kind_t               o_kind,
  output logic      [tlp_pkg::LEN_W-1:0]   o_length,
  output logic      [tlp_pkg::DW_W-1:0]    o_addr,
  output logic      [tlp_pkg::TAG_W-1:0]   o_tag,
  output logic      [tlp_pkg::LADDR_W-1:0] o_lower_addr,
  output logic      [tlp_pkg::STS_W-1:0]   o_sts
);

  logic [tlp_pkg::DW_W-1:0]                     r_hdr [tlp_pkg::HDR_DWORDS];
  logic [tlp_pkg::FMT_W-1:0]                    w_fmt;
  logic [tlp_pkg::FMT_W+tlp_pkg::TYPE_W-1:0]    w_fmt_type;

  always_ff @(posedge clk) begin
    if (i_hdr_we) begin
      r_hdr[i_hdr_idx] <= i_data;
    end
  end

  assign w_fmt      = r_hdr[0][tlp_pkg::FMT_LSB +: tlp_pkg::FMT_W];
  assign w_fmt_type = {w_fmt, r_hdr[0][tlp_pkg::TYPE_LSB +: tlp_pkg::TYPE_W]};

  // Only 3DW headers are parsed
  always_comb begin
    o_kind = tlp_pkg::TLP_UNKNOWN;
    if ((w_fmt == tlp_pkg::FMT_3DW_NO_DATA) || (w_fmt == tlp_pkg::FMT_3DW_DATA)) begin
      case (w_fmt_type)
        tlp_pkg::FT_MWR:  o_kind = tlp_pkg::TLP_MWR;
        tlp_pkg::FT_CPL:  o_kind = tlp_pkg::TLP_CPL;
        tlp_pkg::FT_CPLD: o_kind = tlp_pkg::TLP_CPLD;
        default:          o_kind = tlp_pkg::TLP_UNKNOWN;
      endcase
    end
  end

  assign o_length     = r_hdr[0][tlp_pkg::LEN_LSB +: tlp_pkg::LEN_W];
  assign o_sts        = r_hdr[1][tlp_pkg::STS_LSB +: tlp_pkg::STS_W];
  assign o_tag        = r_hdr[2][tlp_pkg::TAG_LSB +: tlp_pkg::TAG_W];
  assign o_lower_addr = r_hdr[2][tlp_pkg::LADDR_LSB +: tlp_pkg::LADDR_W];

  // Dword aligned write address
  assign o_addr = {r_hdr[2][tlp_pkg::DW_W-1:2], 2'b00};

endmodule

`default_nettype wire

// File: logic/tlp_pkg.sv
//##########################################################################
// TLP packet format definitions for 3DW headers
//##########################################################################
`default_nettype none

package tlp_pkg;

  localparam int DW_W       = 32;
  localparam int LEN_W      = 10;
  localparam int TAG_W      = 8;
  localparam int LADDR_W    = 7;
  localparam int STS_W      = 3;
  localparam int HDR_DWORDS = 3;

  // Header dword 0
  localparam int FMT_LSB  = 29;
  localparam int FMT_W    = 3;
  localparam int TYPE_LSB = 24;
  localparam int TYPE_W   = 5;
  localparam int LEN_LSB  = 0;

  // Completion status lives in dword 1
  localparam int STS_LSB = 13;

  // Completion dword 2
  localparam int TAG_LSB   = 8;
  localparam int LADDR_LSB = 0;

  localparam logic [FMT_W-1:0] FMT_3DW_NO_DATA = 3'b000;
  localparam logic [FMT_W-1:0] FMT_3DW_DATA    = 3'b010;

  // Combined format and type codes
  localparam logic [FMT_W+TYPE_W-1:0] FT_MWR  = 8'h40;
  localparam logic [FMT_W+TYPE_W-1:0] FT_CPL  = 8'h0A;
  localparam logic [FMT_W+TYPE_W-1:0] FT_CPLD = 8'h4A;

  typedef enum logic [1:0] {
    TLP_MWR,
    TLP_CPL,
    TLP_CPLD,
    TLP_UNKNOWN
  } tlp_kind_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the ingress parser testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module pcie_ingress_tb \
  -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "Test failures found" sim.log && exit 1 || grep -q "All tests passed!" sim.log || exit 1
exit 0

// File: src.f
+incdir+include
logic/tlp_pkg.sv
logic/ctrl_pkg.sv
logic/tlp_hdr_capture.sv
logic/ingress_ctrl.sv
logic/reg_write_decoder.sv
logic/cpl_buffer_writer.sv
logic/pcie_ingress.sv
verif/pcie_ingress_tb.sv

// File: include/ingress_vectors.svh
//##########################################################################
// Packet table for the ingress parser testbench
//##########################################################################
`ifndef INGRESS_VECTORS_SVH
`define INGRESS_VECTORS_SVH

// Columns: name, header dwords 0..2, total beats, expected register slot,
// command strobe mask, buffer writes, completion report, count, tag,
// completion status after the packet, unknown strobe, unexpected end strobe
// Register slot 0..5 is a register, 6 a command, 7 ping, 15 nothing
// Mask bits: rst wr rd ping unknown fifo per mem dma from bit 0 upward
typedef struct {
  string       name;
  logic [31:0] h0;
  logic [31:0] h1;
  logic [31:0] h2;
  int          n_beats;
  int          exp_reg;
  logic [8:0]  exp_cmd;
  int          exp_bufwe;
  int          exp_cplt;
  logic [9:0]  exp_cnt;
  logic [7:0]  exp_tag;
  logic [2:0]  exp_sts;
  int          exp_unknown;
  int          exp_unexp;
} vec_t;

localparam int NUM_VECS = 29;

vec_t vectors [NUM_VECS] = '{
  '{"reg_buffer_ready", 32'h40000001, 0, 32'h00010000, 4, 0, 9'h000, 0, 0, 0, 0, 0, 0, 0},
  '{"reg_write_a",      32'h40000001, 0, 32'h00010004, 4, 1, 9'h000, 0, 0, 0, 0, 0, 0, 0},
  '{"reg_write_b",      32'h40000001, 0, 32'h00010008, 4, 2, 9'h000, 0, 0, 0, 0, 0, 0, 0},
  '{"reg_read_a",       32'h40000001, 0, 32'h0001000C, 4, 3, 9'h000, 0, 0, 0, 0, 0, 0, 0},
  '{"reg_read_b",       32'h40000001, 0, 32'h00010010, 4, 4, 9'h000, 0, 0, 0, 0, 0, 0, 0},
  '{"reg_buffer_size",  32'h40000001, 0, 32'h00010014, 4, 5, 9'h000, 0, 0, 0, 0, 0, 0, 0},
  '{"reg_two_dwords",   32'h40000002, 0, 32'h00010004, 5, 1, 9'h000, 0, 0, 0, 0, 0, 0, 0},
  '{"cmd_reset",        32'h40000001, 0, 32'h00010040, 4, 6, 9'h001, 0, 0, 0, 0, 0, 0, 0},
  '{"cmd_per_write",    32'h40000001, 0, 32'h00010044, 4, 6, 9'h042, 0, 0, 0, 0, 0, 0, 0},
  '{"cmd_per_wr_fifo",  32'h40000001, 0, 32'h00010048, 4, 6, 9'h062, 0, 0, 0, 0, 0, 0, 0},
  '{"cmd_per_read",     32'h40000001, 0, 32'h0001004C, 4, 6, 9'h044, 0, 0, 0, 0, 0, 0, 0},
  '{"cmd_per_rd_fifo",  32'h40000001, 0, 32'h00010050, 4, 6, 9'h064, 0, 0, 0, 0, 0, 0, 0},
  '{"cmd_mem_write",    32'h40000001, 0, 32'h00010054, 4, 6, 9'h082, 0, 0, 0, 0, 0, 0, 0},
  '{"cmd_mem_read",     32'h40000001, 0, 32'h00010058, 4, 6, 9'h084, 0, 0, 0, 0, 0, 0, 0},
  '{"cmd_dma_write",    32'h40000001, 0, 32'h0001005C, 4, 6, 9'h102, 0, 0, 0, 0, 0, 0, 0},
  '{"cmd_dma_read",     32'h40000001, 0, 32'h00010060, 4, 6, 9'h104, 0, 0, 0, 0, 0, 0, 0},
  '{"cmd_ping",         32'h40000001, 0, 32'h00010064, 4, 7, 9'h008, 0, 0, 0, 0, 0, 0, 0},
  '{"cmd_unlisted",     32'h40000001, 0, 32'h00010078, 4, 6, 9'h010, 0, 0, 0, 0, 0, 0, 0},
  '{"cpld_len4",        32'h4A000004, 32'h00000000, 32'h00005A10, 7, 15, 9'h000,
    4, 1, 10'd4, 8'h5A, 3'd0, 0, 0},
  '{"cpld_len2_sts2",   32'h4A000002, 32'h00004000, 32'h00001104, 5, 15, 9'h000,
    2, 1, 10'd2, 8'h11, 3'd2, 0, 0},
  '{"cpl_sts0",         32'h0A000000, 32'h00000000, 32'h00000700, 3, 15, 9'h000,
    0, 0, 0, 0, 3'd2, 0, 0},
  '{"cpl_sts1",         32'h0A000000, 32'h00002000, 32'h00000700, 3, 15, 9'h000,
    0, 0, 0, 0, 3'd1, 0, 0},
  '{"mwr_4dw",          32'h60000001, 0, 32'h00010004, 5, 15, 9'h000, 0, 0, 0, 0, 1, 1, 0},
  '{"cfg_write_type",   32'h44000001, 0, 32'h00010004, 4, 15, 9'h000, 0, 0, 0, 0, 1, 1, 0},
  '{"reg_after_unknown", 32'h40000001, 0, 32'h00010008, 4, 2, 9'h000, 0, 0, 0, 0, 1, 0, 0},
  '{"cpld_early_last",  32'h4A000004, 32'h00000000, 32'h00002208, 5, 15, 9'h000,
    2, 0, 0, 0, 3'd1, 0, 1},
  '{"header_truncated", 32'h4A000004, 32'h00000000, 32'h00002208, 2, 15, 9'h000,
    0, 0, 0, 0, 3'd1, 0, 1},
  '{"cpld_after_trunc", 32'h4A000003, 32'h00000000, 32'h00007720, 6, 15, 9'h000,
    3, 1, 10'd3, 8'h77, 3'd1, 0, 0},
  '{"reg_final",        32'h40000001, 0, 32'h00010014, 4, 5, 9'h000, 0, 0, 0, 0, 1, 0, 0}
};

`endif

// File: verif/pcie_ingress_tb.sv
//##########################################################################
// Testbench for the PCIe ingress parser, table driven packet stream
//##########################################################################
`default_nettype none

module pcie_ingress_tb;

  `include "ingress_vectors.svh"

  localparam logic [31:0] CTRL_BASE = 32'h0001_0000;
  localparam logic [12:0] BUF_OFS   = 13'h0008;

  logic        clk;
  logic        rst;
  logic        i_valid;
  logic [31:0] i_data;
  logic        i_last;
  logic [31:0] i_ctrl_base;
  logic [12:0] i_buf_offset;
  logic        o_ready;
  logic [31:0] o_write_a_addr, o_write_b_addr, o_read_a_addr, o_read_b_addr;
  logic [31:0] o_buffer_size, o_ping_value, o_cmd_data_count;
  logic        o_update_buf_stb, o_reg_write_stb;
  logic [1:0]  o_update_buf;
  logic        o_cmd_rst_stb, o_cmd_wr_stb, o_cmd_rd_stb, o_cmd_ping_stb;
  logic        o_cmd_unknown_stb, o_cmd_flg_fifo_stb, o_cmd_flg_sel_per_stb;
  logic        o_cmd_flg_sel_mem_stb, o_cmd_flg_sel_dma_stb;
  logic        o_buf_we;
  logic [10:0] o_buf_addr;
  logic [31:0] o_buf_data;
  logic        o_cplt_pkt_stb, o_unknown_tlp_stb, o_unexpected_end_stb;
  logic [9:0]  o_cplt_pkt_cnt;
  logic [7:0]  o_cplt_pkt_tag;
  logic [2:0]  o_cplt_sts;

  int          errors;
  int          checks;
  int          cycles;
  int          limit;
  logic [31:0] rng;
  string       cur_name;
  logic [31:0] model [8];
  int          cmd_cnt [9];
  int          reg_cnt, upd_cnt, we_cnt, cplt_cnt, unk_cnt, unexp_cnt;
  logic [9:0]  seen_cnt;
  logic [7:0]  seen_tag;
  logic [10:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];

  pcie_ingress u_pcie_ingress (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_val(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp == act) else begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", name, what, exp, act);
    end
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Test failures found");
      $display("timeout: the stream stopped making progress after %0d cycles, checks %0d errors %0d",
               cycles, checks, errors);
      $finish;
    end
  end

  // Output monitor, sampled before the edge updates the registers
  always @(posedge clk) begin
    if (!rst) begin
      reg_cnt    += int'(o_reg_write_stb);
      upd_cnt    += int'(o_update_buf_stb);
      unk_cnt    += int'(o_unknown_tlp_stb);
      unexp_cnt  += int'(o_unexpected_end_stb);
      cmd_cnt[0] += int'(o_cmd_rst_stb);
      cmd_cnt[1] += int'(o_cmd_wr_stb);
      cmd_cnt[2] += int'(o_cmd_rd_stb);
      cmd_cnt[3] += int'(o_cmd_ping_stb);
      cmd_cnt[4] += int'(o_cmd_unknown_stb);
      cmd_cnt[5] += int'(o_cmd_flg_fifo_stb);
      cmd_cnt[6] += int'(o_cmd_flg_sel_per_stb);
      cmd_cnt[7] += int'(o_cmd_flg_sel_mem_stb);
      cmd_cnt[8] += int'(o_cmd_flg_sel_dma_stb);
      if (o_cplt_pkt_stb) begin
        cplt_cnt++;
        seen_cnt = o_cplt_pkt_cnt;
        seen_tag = o_cplt_pkt_tag;
      end
      if (o_buf_we) begin
        we_cnt++;
        assert (exp_addr_q.size() > 0) else begin
          errors++;
          $display("buffer write seen with no payload beat waiting for it");
        end
        if (exp_addr_q.size() > 0) begin
          check_val(cur_name, "buf_addr", 32'(exp_addr_q.pop_front()), 32'(o_buf_addr));
          check_val(cur_name, "buf_data", exp_data_q.pop_front(), o_buf_data);
        end
      end
    end
  end

  task automatic clear_counts();
    reg_cnt   = 0;
    upd_cnt   = 0;
    we_cnt    = 0;
    cplt_cnt  = 0;
    unk_cnt   = 0;
    unexp_cnt = 0;
    for (int i = 0; i < 9; i++) begin
      cmd_cnt[i] = 0;
    end
  endtask

  task automatic send_packet(input int idx);
    logic [31:0] d0;
    logic [31:0] d;
    logic [12:0] base;
    bit          taken;
    base = BUF_OFS - {6'b0, vectors[idx].h2[6:0]};
    d0   = '0;
    for (int b = 0; b < vectors[idx].n_beats; b++) begin
      rng = xorshift(rng);
      if (rng[2:0] == 3'd0) begin
        // Idle cycle inside the packet
        i_valid = 1'b0;
        @(negedge clk);
      end
      rng = xorshift(rng);
      case (b)
        0:       d = vectors[idx].h0;
        1:       d = vectors[idx].h1;
        2:       d = vectors[idx].h2;
        default: d = rng;
      endcase
      if (b == 3) d0 = d;
      if (b >= 3 && (b - 3) < vectors[idx].exp_bufwe) begin
        exp_addr_q.push_back(base[10:0] + 11'(b - 3));
        exp_data_q.push_back(d);
      end
      i_valid = 1'b1;
      i_data  = d;
      i_last  = (b == vectors[idx].n_beats - 1);
      taken   = 1'b0;
      while (!taken) begin
        @(posedge clk);
        taken = o_ready;
      end
      @(negedge clk);
    end
    i_valid = 1'b0;
    i_last  = 1'b0;
    // DONE cycle follows the last beat
    check_val(vectors[idx].name, "o_ready in DONE", 32'd0, 32'(o_ready));
    @(posedge clk);
    @(negedge clk);
    check_val(vectors[idx].name, "o_ready after DONE", 32'd1, 32'(o_ready));
    case (vectors[idx].exp_reg)
      0: model[0] = {30'b0, d0[1:0]};
      1, 2, 3, 4, 5: model[vectors[idx].exp_reg] = d0;
      6: model[6] = d0;
      7: begin
        model[6] = d0;
        model[7] = d0;
      end
      default: ;
    endcase
  endtask

  task automatic check_packet(input int idx);
    string n;
    n = vectors[idx].name;
    check_val(n, "update_buf", model[0], 32'(o_update_buf));
    check_val(n, "write_a", model[1], o_write_a_addr);
    check_val(n, "write_b", model[2], o_write_b_addr);
    check_val(n, "read_a", model[3], o_read_a_addr);
    check_val(n, "read_b", model[4], o_read_b_addr);
    check_val(n, "buffer_size", model[5], o_buffer_size);
    check_val(n, "cmd_data_count", model[6], o_cmd_data_count);
    check_val(n, "ping_value", model[7], o_ping_value);
    check_val(n, "reg_write_stb count", (vectors[idx].exp_reg <= 5) ? 1 : 0, reg_cnt);
    check_val(n, "update_buf_stb count", (vectors[idx].exp_reg == 0) ? 1 : 0, upd_cnt);
    for (int i = 0; i < 9; i++) begin
      check_val(n, $sformatf("cmd strobe %0d count", i), 32'(vectors[idx].exp_cmd[i]),
                cmd_cnt[i]);
    end
    check_val(n, "buf_we count", vectors[idx].exp_bufwe, we_cnt);
    check_val(n, "cplt_pkt_stb count", vectors[idx].exp_cplt, cplt_cnt);
    if (vectors[idx].exp_cplt != 0) begin
      check_val(n, "cplt_pkt_cnt", 32'(vectors[idx].exp_cnt), 32'(seen_cnt));
      check_val(n, "cplt_pkt_tag", 32'(vectors[idx].exp_tag), 32'(seen_tag));
    end
    check_val(n, "cplt_sts", 32'(vectors[idx].exp_sts), 32'(o_cplt_sts));
    check_val(n, "unknown_tlp_stb count", vectors[idx].exp_unknown, unk_cnt);
    check_val(n, "unexpected_end_stb count", vectors[idx].exp_unexp, unexp_cnt);
  endtask

  initial begin
    int beats;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    rng          = 32'h2975;
    cur_name     = "reset";
    beats        = 0;
    for (int i = 0; i < NUM_VECS; i++) begin
      beats += vectors[i].n_beats;
    end
    limit        = beats * 4 + 50;
    rst          = 1'b1;
    i_valid      = 1'b0;
    i_data       = '0;
    i_last       = 1'b0;
    i_ctrl_base  = CTRL_BASE;
    i_buf_offset = BUF_OFS;
    for (int i = 0; i < 8; i++) begin
      model[i] = '0;
    end
    clear_counts();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_val("reset", "o_ready right after reset", 32'd0, 32'(o_ready));
    @(negedge clk);
    check_val("reset", "o_ready one cycle after reset", 32'd1, 32'(o_ready));
    for (int i = 0; i < NUM_VECS; i++) begin
      clear_counts();
      cur_name = vectors[i].name;
      send_packet(i);
      check_packet(i);
    end
    assert (exp_addr_q.size() == 0) else begin
      errors++;
      $display("expected buffer writes never appeared: %0d left", exp_addr_q.size());
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
